//--- project.f
+incdir+hdl
+incdir+verif
hdl/rvfi_trace_pkg.sv
hdl/rvfi_cycle_counter.sv
hdl/rvfi_compressed_decoder.sv
hdl/rvfi_imm_extract.sv
hdl/rvfi_trace_fifo.sv
hdl/rvfi_drain_fsm.sv
hdl/rvfi_trace_top.sv
verif/tb_rvfi_trace.sv

//--- Bender.yml
package:
  name: rvfi_trace

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/rvfi_trace_pkg.sv
      - hdl/rvfi_cycle_counter.sv
      - hdl/rvfi_compressed_decoder.sv
      - hdl/rvfi_imm_extract.sv
      - hdl/rvfi_trace_fifo.sv
      - hdl/rvfi_drain_fsm.sv
      - hdl/rvfi_trace_top.sv
  - target: test
    include_dirs:
      - hdl
      - verif
    files:
      - verif/tb_rvfi_trace.sv

//--- verif/tb_rvfi_trace_ref.svh
// ########################################
// Reference model for the trace testbench
// RVC expansion from decoded fields and immediate rules
// ########################################

`ifndef TB_RVFI_TRACE_REF_SVH
`define TB_RVFI_TRACE_REF_SVH

// Rebuilds each supported compressed form through its own offsets and fields
function automatic void expand_rvc(input logic [31:0] insn, output logic [31:0] exp,
                                   output logic comp, output logic ill);
  logic [15:0] c;
  logic [4:0]  rd;
  logic [4:0]  rs2;
  logic [4:0]  rdp;
  logic [4:0]  rs1p;
  logic [31:0] imm6;
  logic [31:0] off;
  c    = insn[15:0];
  rd   = c[11:7];
  rs2  = c[6:2];
  rdp  = 5'd8 + c[4:2];
  rs1p = 5'd8 + c[9:7];
  imm6 = {{26{c[12]}}, c[12], c[6:2]};
  exp  = insn;
  comp = 1'b0;
  ill  = 1'b0;
  if (c[1:0] != 2'b11) begin
    comp = 1'b1;
    exp  = 32'h0;
    off  = {25'h0, c[5], c[12:10], c[6], 2'b00};
    case ({c[1:0], c[15:13]})
      5'b00_010: exp = {off[11:0], rs1p, 3'b010, rdp, 7'b0000011};
      5'b00_110: exp = {off[11:5], rdp, rs1p, 3'b010, off[4:0], 7'b0100011};
      5'b01_000: exp = {imm6[11:0], rd, 3'b000, rd, 7'b0010011};
      5'b01_010: exp = {imm6[11:0], 5'd0, 3'b000, rd, 7'b0010011};
      5'b01_011: begin
        if (rd == 5'd2) ill = 1'b1;
        else exp = {imm6[19:0], rd, 7'b0110111};
      end
      5'b01_001, 5'b01_101: begin
        off = {{20{c[12]}}, c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], 1'b0};
        exp = {off[20], off[10:1], off[11], off[19:12], 4'b0, ~c[15], 7'b1101111};
      end
      5'b01_110, 5'b01_111: begin
        off = {{23{c[12]}}, c[12], c[6:5], c[2], c[11:10], c[4:3], 1'b0};
        exp = {off[12], off[10:5], 5'd0, rs1p, 2'b00, c[13], off[4:1], off[11],
               7'b1100011};
      end
      5'b10_100: begin
        if (rs2 == 5'd0) ill = 1'b1;
        else if (c[12]) exp = {7'b0, rs2, rd, 3'b000, rd, 7'b0110011};
        else exp = {7'b0, rs2, 5'd0, 3'b000, rd, 7'b0110011};
      end
      default: ill = 1'b1;
    endcase
  end
endfunction

// Immediate format and value from the major opcode
function automatic void extract_imm(input logic [31:0] i,
                                    output rvfi_trace_pkg::imm_fmt_e fmt,
                                    output logic [31:0] imm);
  fmt = rvfi_trace_pkg::IMM_NONE;
  imm = 32'h0;
  case (i[6:0])
    7'b0000011, 7'b0010011, 7'b1100111: begin
      fmt = rvfi_trace_pkg::IMM_I;
      imm = {{21{i[31]}}, i[30:20]};
    end
    7'b0100011: begin
      fmt = rvfi_trace_pkg::IMM_S;
      imm = {{21{i[31]}}, i[30:25], i[11:7]};
    end
    7'b1100011: begin
      fmt        = rvfi_trace_pkg::IMM_SB;
      imm[31:12] = {20{i[31]}};
      imm[11]    = i[7];
      imm[10:5]  = i[30:25];
      imm[4:1]   = i[11:8];
    end
    7'b0110111, 7'b0010111: begin
      fmt = rvfi_trace_pkg::IMM_U;
      imm = i & 32'hffff_f000;
    end
    7'b1101111: begin
      fmt        = rvfi_trace_pkg::IMM_UJ;
      imm[31:20] = {12{i[31]}};
      imm[19:12] = i[19:12];
      imm[11]    = i[20];
      imm[10:1]  = i[30:21];
    end
    default: ;
  endcase
endfunction

`endif

//--- verif/tb_rvfi_trace.sv
// ########################################
// Testbench of the RVFI trace unit
// Random retires, modelled buffer occupancy, req/ack collector
// ########################################

`include "rvfi_trace_params.svh"

module tb_rvfi_trace;

  timeunit 1ns;
  timeprecision 1ps;

  `include "tb_rvfi_trace_ref.svh"

  localparam int DEPTH = `RVFI_TRACE_DEPTH;

  logic                      clk_i;
  logic                      rst_ni;
  rvfi_trace_pkg::word_t     hart_id;
  logic                      rvfi_valid;
  rvfi_trace_pkg::word_t     rvfi_insn;
  rvfi_trace_pkg::word_t     rvfi_pc;
  rvfi_trace_pkg::reg_addr_t rvfi_rd_addr;
  rvfi_trace_pkg::word_t     rvfi_rd_wdata;
  logic                      trace_ack;
  logic                      trace_req;
  rvfi_trace_pkg::word_t     out_hart;
  rvfi_trace_pkg::word_t     out_pc;
  rvfi_trace_pkg::word_t     out_insn;
  rvfi_trace_pkg::word_t     out_exp;
  rvfi_trace_pkg::cycle_t    out_cycle;
  logic                      out_comp;
  logic                      out_ill;
  rvfi_trace_pkg::imm_fmt_e  out_fmt;
  rvfi_trace_pkg::word_t     out_imm;
  rvfi_trace_pkg::word_t     out_rdw;
  rvfi_trace_pkg::reg_addr_t out_rda;
  rvfi_trace_pkg::drop_cnt_t drop_count;

  // Expected records as one queue per field
  rvfi_trace_pkg::cycle_t    q_cycle[$];
  rvfi_trace_pkg::word_t     q_pc[$];
  rvfi_trace_pkg::word_t     q_insn[$];
  rvfi_trace_pkg::word_t     q_exp[$];
  logic                      q_comp[$];
  logic                      q_ill[$];
  rvfi_trace_pkg::imm_fmt_e  q_fmt[$];
  rvfi_trace_pkg::word_t     q_imm[$];
  rvfi_trace_pkg::word_t     q_rdw[$];
  rvfi_trace_pkg::reg_addr_t q_rda[$];

  // Record sitting in the capture stage
  logic                      pend;
  rvfi_trace_pkg::cycle_t    pend_cycle;
  rvfi_trace_pkg::word_t     pend_pc;
  rvfi_trace_pkg::word_t     pend_insn;
  rvfi_trace_pkg::word_t     pend_exp;
  logic                      pend_comp;
  logic                      pend_ill;
  rvfi_trace_pkg::imm_fmt_e  pend_fmt;
  rvfi_trace_pkg::word_t     pend_imm;
  rvfi_trace_pkg::word_t     pend_rdw;
  rvfi_trace_pkg::reg_addr_t pend_rda;

  rvfi_trace_pkg::cycle_t    tb_cycle;
  rvfi_trace_pkg::drop_cnt_t exp_drop;
  rvfi_trace_pkg::drop_cnt_t drop_base;
  int                        occ;
  logic                      req_prev;
  logic                      ack_prev;
  logic                      hold_ack;
  logic                      abort;
  logic [31:0]               rng;
  logic [31:0]               ack_rng;
  int                        mismatches;
  int                        timeouts;
  int                        protocol_errs;

  rvfi_trace_top dut (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .hart_id_i          (hart_id),
    .rvfi_valid_i       (rvfi_valid),
    .rvfi_insn_i        (rvfi_insn),
    .rvfi_pc_rdata_i    (rvfi_pc),
    .rvfi_rd_addr_i     (rvfi_rd_addr),
    .rvfi_rd_wdata_i    (rvfi_rd_wdata),
    .trace_ack_i        (trace_ack),
    .trace_req_o        (trace_req),
    .trace_hart_o       (out_hart),
    .trace_pc_o         (out_pc),
    .trace_insn_o       (out_insn),
    .trace_insn_exp_o   (out_exp),
    .trace_cycle_o      (out_cycle),
    .trace_compressed_o (out_comp),
    .trace_illegal_o    (out_ill),
    .trace_imm_fmt_o    (out_fmt),
    .trace_imm_o        (out_imm),
    .trace_rd_wdata_o   (out_rdw),
    .trace_rd_addr_o    (out_rda),
    .drop_count_o       (drop_count)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Mix of full-width, supported RVC and arbitrary RVC words
  function automatic logic [31:0] pick_insn(input logic [31:0] r1, input logic [31:0] r2);
    logic [6:0] opcs [10];
    logic [4:0] qf   [10];
    logic [15:0] c;
    opcs = '{7'b0000011, 7'b0010011, 7'b0010111, 7'b0100011, 7'b0110011,
             7'b0110111, 7'b1100011, 7'b1100111, 7'b1101111, 7'b1110011};
    qf   = '{5'b00_010, 5'b00_110, 5'b01_000, 5'b01_001, 5'b01_010,
             5'b01_011, 5'b01_101, 5'b01_110, 5'b01_111, 5'b10_100};
    case (r1[1:0])
      2'd2: begin
        c = {qf[r2[31:16] % 10][2:0], r2[12:2], qf[r2[31:16] % 10][4:3]};
        return {16'h0, c};
      end
      2'd3: return {16'h0, r2[15:1], 1'b0};
      default: return {r2[31:7], opcs[r1[31:16] % 10]};
    endcase
  endfunction

  task automatic check_word(input string what, input rvfi_trace_pkg::word_t got,
                            input rvfi_trace_pkg::word_t exp);
    if (got !== exp) begin
      mismatches++;
      $display("mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_cycle(input rvfi_trace_pkg::cycle_t got,
                             input rvfi_trace_pkg::cycle_t exp);
    if (got !== exp) begin
      mismatches++;
      $display("mismatch at %0t ns: timestamp got %0d expected %0d", $time, got, exp);
    end
  endtask

  task automatic check_fmt(input rvfi_trace_pkg::imm_fmt_e got,
                           input rvfi_trace_pkg::imm_fmt_e exp);
    if (got !== exp) begin
      mismatches++;
      $display("mismatch at %0t ns: imm format got %0d expected %0d", $time, got, exp);
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      mismatches++;
      $display("mismatch at %0t ns: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_drop(input rvfi_trace_pkg::drop_cnt_t got,
                            input rvfi_trace_pkg::drop_cnt_t exp);
    if (got !== exp) begin
      mismatches++;
      $display("mismatch at %0t ns: drop count got %0d expected %0d", $time, got, exp);
    end
  endtask

  task automatic report_timeout(input string what);
    timeouts++;
    abort = 1'b1;
    $display("Timed out at %0t ns while waiting for %s", $time, what);
  endtask

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // Predicts buffer contents from pre-edge values at every rising edge
  always @(posedge clk_i) begin
    if (!rst_ni) begin
      tb_cycle = '0;
      occ      = 0;
      pend     = 1'b0;
      exp_drop = '0;
      req_prev = 1'b0;
      ack_prev = 1'b0;
    end else begin
      if (pend) begin
        if (occ == DEPTH) begin
          if (exp_drop != '1) exp_drop++;
        end else begin
          q_cycle.push_back(pend_cycle);
          q_pc.push_back(pend_pc);
          q_insn.push_back(pend_insn);
          q_exp.push_back(pend_exp);
          q_comp.push_back(pend_comp);
          q_ill.push_back(pend_ill);
          q_fmt.push_back(pend_fmt);
          q_imm.push_back(pend_imm);
          q_rdw.push_back(pend_rdw);
          q_rda.push_back(pend_rda);
          occ++;
        end
      end
      if (trace_req && trace_ack) occ--;
      // Request rose just after the previous edge, when acknowledge was ack_prev
      if (trace_req && !req_prev && ack_prev) begin
        protocol_errs++;
        $display("Request rose at %0t ns while acknowledge was still high", $time);
      end
      req_prev = trace_req;
      ack_prev = trace_ack;
      pend     = rvfi_valid;
      if (rvfi_valid) begin
        pend_cycle = tb_cycle;
        pend_pc    = rvfi_pc;
        pend_insn  = rvfi_insn;
        pend_rdw   = rvfi_rd_wdata;
        pend_rda   = rvfi_rd_addr;
        expand_rvc(rvfi_insn, pend_exp, pend_comp, pend_ill);
        extract_imm(pend_exp, pend_fmt, pend_imm);
      end
      tb_cycle++;
    end
  end

  // Collector side of the four-phase handshake
  initial begin
    int idle;
    int n;
    idle = 0;
    forever begin
      @(posedge clk_i);
      #1;
      if (!rst_ni || abort) begin
        idle = 0;
      end else if (!trace_req) begin
        if (q_pc.size() != 0 && !hold_ack) idle++;
        if (idle > 40) report_timeout("request with records pending");
      end else if (q_pc.size() == 0) begin
        protocol_errs++;
        abort = 1'b1;
        $display("Request raised at %0t ns with no record expected", $time);
      end else begin
        idle = 0;
        check_cycle(out_cycle, q_cycle.pop_front());
        check_word("pc", out_pc, q_pc.pop_front());
        check_word("insn", out_insn, q_insn.pop_front());
        check_word("insn_exp", out_exp, q_exp.pop_front());
        check_flag("compressed", out_comp, q_comp.pop_front());
        check_flag("illegal", out_ill, q_ill.pop_front());
        check_fmt(out_fmt, q_fmt.pop_front());
        check_word("imm", out_imm, q_imm.pop_front());
        check_word("rd_wdata", out_rdw, q_rdw.pop_front());
        check_word("rd_addr", {27'h0, out_rda}, {27'h0, q_rda.pop_front()});
        check_word("hart", out_hart, hart_id);
        n = 0;
        while (hold_ack && n < 300) begin
          @(posedge clk_i);
          #1;
          n++;
        end
        if (hold_ack) report_timeout("acknowledge release");
        ack_rng = xorshift32(ack_rng);
        repeat (ack_rng[1:0]) begin
          @(posedge clk_i);
          #1;
        end
        trace_ack = 1'b1;
        n = 0;
        do begin
          @(posedge clk_i);
          #1;
          n++;
        end while (trace_req && n < 20);
        if (trace_req) report_timeout("request low");
        // Acknowledge stays high a few more cycles before its release
        repeat (ack_rng[3:2]) begin
          @(posedge clk_i);
          #1;
        end
        trace_ack = 1'b0;
      end
    end
  end

  task automatic drive_retire(input logic valid);
    logic [31:0] r1;
    logic [31:0] r2;
    rng = xorshift32(rng);
    r1  = rng;
    rng = xorshift32(rng);
    r2  = rng;
    rvfi_valid    = valid;
    rvfi_insn     = pick_insn(r1, r2);
    rvfi_pc       = {r2[27:0], r1[7:6], 2'b00};
    rvfi_rd_addr  = r1[12:8];
    rvfi_rd_wdata = r1 ^ r2;
    @(posedge clk_i);
    #1;
  endtask

  task automatic wait_drained();
    int n;
    n = 0;
    while ((q_pc.size() != 0 || pend || trace_req || trace_ack) && n < 600 && !abort) begin
      @(posedge clk_i);
      #1;
      n++;
    end
    if (n >= 600) report_timeout("the buffer to drain");
  endtask

  initial begin
    rst_ni        = 1'b0;
    hart_id       = 32'h0000_0003;
    rvfi_valid    = 1'b0;
    rvfi_insn     = '0;
    rvfi_pc       = '0;
    rvfi_rd_addr  = '0;
    rvfi_rd_wdata = '0;
    trace_ack     = 1'b0;
    hold_ack      = 1'b0;
    abort         = 1'b0;
    mismatches    = 0;
    timeouts      = 0;
    protocol_errs = 0;
    rng           = 32'h387c_fe42;
    ack_rng       = xorshift32(32'h387c_fe42);
    repeat (16) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    check_flag("request after reset", trace_req, 1'b0);
    check_drop(drop_count, '0);
    repeat (10) begin
      @(posedge clk_i);
      #1;
      check_flag("request with no retires", trace_req, 1'b0);
    end
    // Random retires with gaps
    for (int i = 0; i < 400 && !abort; i++) begin
      drive_retire(rng[3:2] != 2'b00);
    end
    rvfi_valid = 1'b0;
    wait_drained();
    // Burst past capacity with acknowledge withheld
    if (!abort) begin
      drop_base = exp_drop;
      hold_ack  = 1'b1;
      repeat (DEPTH + 5) drive_retire(1'b1);
      rvfi_valid = 1'b0;
      repeat (4) @(posedge clk_i);
      #1;
      check_drop(drop_count, drop_base + 5);
      check_drop(exp_drop, drop_base + 5);
      hold_ack = 1'b0;
      wait_drained();
    end
    check_drop(drop_count, exp_drop);
    $display("errors: mismatches=%0d timeouts=%0d protocol=%0d",
             mismatches, timeouts, protocol_errs);
    if (mismatches == 0 && timeouts == 0 && protocol_errs == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

//--- hdl/rvfi_trace_top.sv
// ########################################
// RVFI retirement trace capture unit
// Registers retire events, decodes them and queues records
// for a req/ack collector
// ########################################

module rvfi_trace_top (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  rvfi_trace_pkg::word_t     hart_id_i,
  input  logic                      rvfi_valid_i,
  input  rvfi_trace_pkg::word_t     rvfi_insn_i,
  input  rvfi_trace_pkg::word_t     rvfi_pc_rdata_i,
  input  rvfi_trace_pkg::reg_addr_t rvfi_rd_addr_i,
  input  rvfi_trace_pkg::word_t     rvfi_rd_wdata_i,
  input  logic                      trace_ack_i,
  output logic                      trace_req_o,
  output rvfi_trace_pkg::word_t     trace_hart_o,
  output rvfi_trace_pkg::word_t     trace_pc_o,
  output rvfi_trace_pkg::word_t     trace_insn_o,
  output rvfi_trace_pkg::word_t     trace_insn_exp_o,
  output rvfi_trace_pkg::cycle_t    trace_cycle_o,
  output logic                      trace_compressed_o,
  output logic                      trace_illegal_o,
  output rvfi_trace_pkg::imm_fmt_e  trace_imm_fmt_o,
  output rvfi_trace_pkg::word_t     trace_imm_o,
  output rvfi_trace_pkg::word_t     trace_rd_wdata_o,
  output rvfi_trace_pkg::reg_addr_t trace_rd_addr_o,
  output rvfi_trace_pkg::drop_cnt_t drop_count_o
);

  rvfi_trace_pkg::cycle_t    cycle_now;
  logic                      cap_valid_q;
  rvfi_trace_pkg::cycle_t    cap_cycle_q;
  rvfi_trace_pkg::word_t     cap_insn_q;
  rvfi_trace_pkg::word_t     cap_pc_q;
  rvfi_trace_pkg::reg_addr_t cap_rd_addr_q;
  rvfi_trace_pkg::word_t     cap_rd_wdata_q;
  rvfi_trace_pkg::word_t     insn_exp;
  logic                      is_compressed;
  logic                      is_illegal;
  rvfi_trace_pkg::imm_fmt_e  imm_fmt;
  rvfi_trace_pkg::word_t     imm;
  logic                      fifo_empty;
  logic                      fifo_pop;

  rvfi_cycle_counter u_cycle_counter (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .count_o (cycle_now)
  );

  // Capture stage; only the valid bit needs a reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cap_valid_q <= 1'b0;
    end else begin
      cap_valid_q <= rvfi_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rvfi_valid_i) begin
      cap_cycle_q    <= cycle_now;
      cap_insn_q     <= rvfi_insn_i;
      cap_pc_q       <= rvfi_pc_rdata_i;
      cap_rd_addr_q  <= rvfi_rd_addr_i;
      cap_rd_wdata_q <= rvfi_rd_wdata_i;
    end
  end

  rvfi_compressed_decoder u_decoder (
    .instr_i         (cap_insn_q),
    .instr_o         (insn_exp),
    .is_compressed_o (is_compressed),
    .illegal_o       (is_illegal)
  );

  // Immediate comes from the expanded form
  rvfi_imm_extract u_imm_extract (
    .instr_i (insn_exp),
    .fmt_o   (imm_fmt),
    .imm_o   (imm)
  );

  rvfi_trace_fifo u_fifo (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .push_i       (cap_valid_q),
    .pop_i        (fifo_pop),
    .cycle_i      (cap_cycle_q),
    .pc_i         (cap_pc_q),
    .insn_i       (cap_insn_q),
    .insn_exp_i   (insn_exp),
    .compressed_i (is_compressed),
    .illegal_i    (is_illegal),
    .imm_fmt_i    (imm_fmt),
    .imm_i        (imm),
    .rd_wdata_i   (cap_rd_wdata_q),
    .rd_addr_i    (cap_rd_addr_q),
    .cycle_o      (trace_cycle_o),
    .pc_o         (trace_pc_o),
    .insn_o       (trace_insn_o),
    .insn_exp_o   (trace_insn_exp_o),
    .compressed_o (trace_compressed_o),
    .illegal_o    (trace_illegal_o),
    .imm_fmt_o    (trace_imm_fmt_o),
    .imm_o        (trace_imm_o),
    .rd_wdata_o   (trace_rd_wdata_o),
    .rd_addr_o    (trace_rd_addr_o),
    .empty_o      (fifo_empty),
    .full_o       (),
    .drop_count_o (drop_count_o)
  );

  rvfi_drain_fsm u_drain_fsm (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .empty_i     (fifo_empty),
    .trace_ack_i (trace_ack_i),
    .pop_o       (fifo_pop),
    .trace_req_o (trace_req_o)
  );

  // Hart id only tags the outgoing record
  assign trace_hart_o = hart_id_i;

endmodule

//--- hdl/rvfi_drain_fsm.sv
// ########################################
// Four-phase req/ack drain of the record buffer
// Pops the head record on the first acknowledged edge
// ########################################

module rvfi_drain_fsm (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic empty_i,
  input  logic trace_ack_i,
  output logic pop_o,
  output logic trace_req_o
);

  rvfi_trace_pkg::drain_state_e state_q;
  rvfi_trace_pkg::drain_state_e state_d;
  logic                         req;

  always_comb begin
    state_d = state_q;

    case (state_q)
      rvfi_trace_pkg::DRAIN_IDLE: begin
        if (!empty_i) begin
          state_d = rvfi_trace_pkg::DRAIN_REQ;
        end
      end

      rvfi_trace_pkg::DRAIN_REQ: begin
        if (trace_ack_i) begin
          state_d = rvfi_trace_pkg::DRAIN_WAIT_ACK_LOW;
        end
      end

      // Collector must release ack before the next request
      rvfi_trace_pkg::DRAIN_WAIT_ACK_LOW: begin
        if (!trace_ack_i) begin
          state_d = rvfi_trace_pkg::DRAIN_IDLE;
        end
      end

      default: begin
        state_d = rvfi_trace_pkg::DRAIN_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= rvfi_trace_pkg::DRAIN_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign req         = (state_q == rvfi_trace_pkg::DRAIN_REQ);
  assign trace_req_o = req;
  // Single-cycle pop, the state leaves REQ on the same edge
  assign pop_o       = req && trace_ack_i;

endmodule

//--- hdl/rvfi_trace_fifo.sv
// ########################################
// Circular buffer of trace records
// Full pushes are dropped and counted, saturating
// ########################################

`include "rvfi_trace_params.svh"

module rvfi_trace_fifo (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      push_i,
  input  logic                      pop_i,
  input  rvfi_trace_pkg::cycle_t    cycle_i,
  input  rvfi_trace_pkg::word_t     pc_i,
  input  rvfi_trace_pkg::word_t     insn_i,
  input  rvfi_trace_pkg::word_t     insn_exp_i,
  input  logic                      compressed_i,
  input  logic                      illegal_i,
  input  rvfi_trace_pkg::imm_fmt_e  imm_fmt_i,
  input  rvfi_trace_pkg::word_t     imm_i,
  input  rvfi_trace_pkg::word_t     rd_wdata_i,
  input  rvfi_trace_pkg::reg_addr_t rd_addr_i,
  output rvfi_trace_pkg::cycle_t    cycle_o,
  output rvfi_trace_pkg::word_t     pc_o,
  output rvfi_trace_pkg::word_t     insn_o,
  output rvfi_trace_pkg::word_t     insn_exp_o,
  output logic                      compressed_o,
  output logic                      illegal_o,
  output rvfi_trace_pkg::imm_fmt_e  imm_fmt_o,
  output rvfi_trace_pkg::word_t     imm_o,
  output rvfi_trace_pkg::word_t     rd_wdata_o,
  output rvfi_trace_pkg::reg_addr_t rd_addr_o,
  output logic                      empty_o,
  output logic                      full_o,
  output rvfi_trace_pkg::drop_cnt_t drop_count_o
);

  localparam int unsigned DEPTH  = `RVFI_TRACE_DEPTH;
  localparam int unsigned ADDR_W = $clog2(DEPTH);
  localparam int unsigned REC_W  = $bits(rvfi_trace_pkg::cycle_t) + 5 * 32 + 2 + 3 + 5;

  logic [REC_W-1:0]          mem_q [DEPTH];
  logic [REC_W-1:0]          wr_rec;
  logic [REC_W-1:0]          rd_rec;
  logic [2:0]                rd_fmt;
  logic [ADDR_W:0]           wr_ptr_q;
  logic [ADDR_W:0]           rd_ptr_q;
  logic                      do_push;
  logic                      do_pop;
  rvfi_trace_pkg::drop_cnt_t drop_cnt_q;

  // Pointers carry one extra wrap bit to tell full from empty
  assign empty_o = (wr_ptr_q == rd_ptr_q);
  assign full_o  = (wr_ptr_q[ADDR_W] != rd_ptr_q[ADDR_W]) &&
                   (wr_ptr_q[ADDR_W-1:0] == rd_ptr_q[ADDR_W-1:0]);
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  assign wr_rec = {cycle_i, pc_i, insn_i, insn_exp_i, compressed_i, illegal_i,
                   imm_fmt_i, imm_i, rd_wdata_i, rd_addr_i};
  assign rd_rec = mem_q[rd_ptr_q[ADDR_W-1:0]];
  assign {cycle_o, pc_o, insn_o, insn_exp_o, compressed_o, illegal_o,
          rd_fmt, imm_o, rd_wdata_o, rd_addr_o} = rd_rec;
  assign imm_fmt_o = rvfi_trace_pkg::imm_fmt_e'(rd_fmt);

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q[ADDR_W-1:0]] <= wr_rec;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      drop_cnt_q <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      // Count lost records, hold at the top value
      if (push_i && full_o && (drop_cnt_q != '1)) begin
        drop_cnt_q <= drop_cnt_q + 1'b1;
      end
    end
  end

  assign drop_count_o = drop_cnt_q;

endmodule

//--- hdl/rvfi_imm_extract.sv
// ########################################
// Finds the immediate format of an expanded instruction
// and builds its sign-extended value
// ########################################

module rvfi_imm_extract (
  input  rvfi_trace_pkg::word_t    instr_i,
  output rvfi_trace_pkg::imm_fmt_e fmt_o,
  output rvfi_trace_pkg::word_t    imm_o
);

  always_comb begin
    fmt_o = rvfi_trace_pkg::IMM_NONE;
    imm_o = '0;

    case (instr_i[6:0])
      rvfi_trace_pkg::OPC_LOAD,
      rvfi_trace_pkg::OPC_OP_IMM,
      rvfi_trace_pkg::OPC_JALR: begin
        fmt_o = rvfi_trace_pkg::IMM_I;
        imm_o = {{20{instr_i[31]}}, instr_i[31:20]};
      end

      rvfi_trace_pkg::OPC_STORE: begin
        fmt_o = rvfi_trace_pkg::IMM_S;
        imm_o = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
      end

      // Branch offsets are in halfwords, bit 0 is always zero
      rvfi_trace_pkg::OPC_BRANCH: begin
        fmt_o = rvfi_trace_pkg::IMM_SB;
        imm_o = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
      end

      rvfi_trace_pkg::OPC_LUI,
      rvfi_trace_pkg::OPC_AUIPC: begin
        fmt_o = rvfi_trace_pkg::IMM_U;
        imm_o = {instr_i[31:12], 12'b0};
      end

      rvfi_trace_pkg::OPC_JAL: begin
        fmt_o = rvfi_trace_pkg::IMM_UJ;
        imm_o = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};
      end

      default: begin
        fmt_o = rvfi_trace_pkg::IMM_NONE;
        imm_o = '0;
      end
    endcase
  end

endmodule

//--- hdl/rvfi_compressed_decoder.sv
// ########################################
// Expands a subset of RV32C into 32-bit instructions
// Combinational; unsupported compressed words give zero and illegal
// ########################################

module rvfi_compressed_decoder (
  input  rvfi_trace_pkg::word_t instr_i,
  output rvfi_trace_pkg::word_t instr_o,
  output logic                  is_compressed_o,
  output logic                  illegal_o
);

  logic [15:0] c;

  assign c = instr_i[15:0];

  always_comb begin
    instr_o         = instr_i;
    is_compressed_o = 1'b0;
    illegal_o       = 1'b0;

    // Low bits 11 mark a full-width instruction
    if (c[1:0] != 2'b11) begin
      is_compressed_o = 1'b1;
      instr_o         = '0;

      // Quadrant and funct3 select the instruction
      case ({c[1:0], c[15:13]})
        // C.LW
        5'b00_010: begin
          instr_o = {5'b0, c[5], c[12:10], c[6], 2'b00, 2'b01, c[9:7], 3'b010,
                     2'b01, c[4:2], rvfi_trace_pkg::OPC_LOAD};
        end

        // C.SW
        5'b00_110: begin
          instr_o = {5'b0, c[5], c[12], 2'b01, c[4:2], 2'b01, c[9:7], 3'b010,
                     c[11:10], c[6], 2'b00, rvfi_trace_pkg::OPC_STORE};
        end

        // C.ADDI
        5'b01_000: begin
          instr_o = {{6{c[12]}}, c[12], c[6:2], c[11:7], 3'b000, c[11:7],
                     rvfi_trace_pkg::OPC_OP_IMM};
        end

        // C.JAL and C.J, bit 15 tells them apart
        5'b01_001, 5'b01_101: begin
          instr_o = {c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3],
                     {9{c[12]}}, 4'b0, ~c[15], rvfi_trace_pkg::OPC_JAL};
        end

        // C.LI
        5'b01_010: begin
          instr_o = {{6{c[12]}}, c[12], c[6:2], 5'b0, 3'b000, c[11:7],
                     rvfi_trace_pkg::OPC_OP_IMM};
        end

        // C.LUI, rd of x2 is C.ADDI16SP which is not supported
        5'b01_011: begin
          if (c[11:7] == 5'd2) begin
            illegal_o = 1'b1;
          end else begin
            instr_o = {{15{c[12]}}, c[6:2], c[11:7], rvfi_trace_pkg::OPC_LUI};
          end
        end

        // C.BEQZ and C.BNEZ, bit 13 becomes funct3[0]
        5'b01_110, 5'b01_111: begin
          instr_o = {{4{c[12]}}, c[6:5], c[2], 5'b0, 2'b01, c[9:7], 2'b00, c[13],
                     c[11:10], c[4:3], c[12], rvfi_trace_pkg::OPC_BRANCH};
        end

        // C.MV and C.ADD; rs2 of x0 is a jump or ebreak
        5'b10_100: begin
          if (c[6:2] == 5'd0) begin
            illegal_o = 1'b1;
          end else if (c[12]) begin
            instr_o = {7'b0, c[6:2], c[11:7], 3'b000, c[11:7], rvfi_trace_pkg::OPC_OP};
          end else begin
            instr_o = {7'b0, c[6:2], 5'b0, 3'b000, c[11:7], rvfi_trace_pkg::OPC_OP};
          end
        end

        default: begin
          illegal_o = 1'b1;
        end
      endcase
    end
  end

endmodule

//--- hdl/rvfi_cycle_counter.sv
// ########################################
// Free-running timestamp counter
// Wraps at the width of cycle_t
// ########################################

module rvfi_cycle_counter (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  output rvfi_trace_pkg::cycle_t count_o
);

  rvfi_trace_pkg::cycle_t count_q;

  // Zero on the first edge out of reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q <= '0;
    end else begin
      count_q <= count_q + 1'b1;
    end
  end

  assign count_o = count_q;

endmodule

//--- hdl/rvfi_trace_pkg.sv
// ########################################
// Shared types and opcode values of the RVFI trace unit
// Reached from other files by scoped names
// ########################################

`include "rvfi_trace_params.svh"

package rvfi_trace_pkg;

  typedef logic [31:0]                    word_t;
  typedef logic [4:0]                     reg_addr_t;
  typedef logic [`RVFI_TRACE_CYCLE_W-1:0] cycle_t;
  typedef logic [`RVFI_TRACE_DROP_W-1:0]  drop_cnt_t;

  // Immediate format of a retired instruction
  typedef enum logic [2:0] {
    IMM_NONE,
    IMM_I,
    IMM_S,
    IMM_SB,
    IMM_U,
    IMM_UJ
  } imm_fmt_e;

  // Drain handshake states
  typedef enum logic [1:0] {
    DRAIN_IDLE,
    DRAIN_REQ,
    DRAIN_WAIT_ACK_LOW
  } drain_state_e;

  // RV32I major opcodes
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;

endpackage

//--- hdl/rvfi_trace_params.svh
// ########################################
// Build-time sizes of the RVFI trace unit
// Included by the package and the record buffer
// ########################################

`ifndef RVFI_TRACE_PARAMS_SVH
`define RVFI_TRACE_PARAMS_SVH

// Record buffer depth, must be a power of two
`define RVFI_TRACE_DEPTH 8

// Timestamp width in bits
`define RVFI_TRACE_CYCLE_W 32

// Width of the dropped-record counter
`define RVFI_TRACE_DROP_W 16

`endif
